// ==== sim.f ====
+incdir+bench
design/lsu_pkg.sv
design/data_bus_if.sv
design/lsu_ctrl.sv
design/store_align.sv
design/load_extract.sv
design/data_sram.sv
design/lsu_top.sv
bench/tb_lsu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the LSU simulation with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_lsu -f sim.f -o tb_lsu \
  && ./obj_dir/tb_lsu \
  || exit 1

// ==== bench/lsu_model.svh ====
// LSU reference model
// Byte-addressed mirror of the data memory and the expected load results

`ifndef LSU_MODEL_SVH
`define LSU_MODEL_SVH

localparam int MODEL_BYTES = 4 * 256;

logic [7:0] model_mem [MODEL_BYTES];

// Store of one, two or four bytes starting at the byte address
function automatic void store_bytes(input logic [31:0] a, input logic [2:0] f3,
                                    input logic [31:0] data);
  int base;
  int n;
  base = int'(a[9:0]);
  n = (f3[1:0] == 2'b00) ? 1 : ((f3[1:0] == 2'b01) ? 2 : 4);
  for (int i = 0; i < n; i++) begin
    model_mem[base + i] = data[8*i +: 8];
  end
endfunction

// Loaded value after sign or zero extension
function automatic logic [31:0] expected_load(input logic [31:0] a, input logic [2:0] f3);
  int i;
  i = int'(a[9:0]);
  case (f3)
    lsu_pkg::FUNCT3_B:  return {{24{model_mem[i][7]}}, model_mem[i]};
    lsu_pkg::FUNCT3_BU: return {24'h0, model_mem[i]};
    lsu_pkg::FUNCT3_H:  return {{16{model_mem[i+1][7]}}, model_mem[i+1], model_mem[i]};
    lsu_pkg::FUNCT3_HU: return {16'h0, model_mem[i+1], model_mem[i]};
    default: begin
      return {model_mem[i+3], model_mem[i+2], model_mem[i+1], model_mem[i]};
    end
  endcase
endfunction

`endif

// ==== bench/tb_lsu.sv ====
// LSU testbench
// Random loads and stores checked against a byte model and for fixed latency

`timescale 1ns/1ps

module tb_lsu;

  localparam int MEM_WORDS = 256;
  localparam int SEED = 32'hffdf;
  localparam int N_SUB_STORES = 200;
  localparam int N_SUB_LOADS = 300;
  localparam int N_MIX = 2000;
  localparam int TOTAL_OPS = 2 * MEM_WORDS + 2 * N_SUB_STORES + N_SUB_LOADS + N_MIX;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_OPS + 200;

  logic        clk;
  logic        rst_n;
  logic [31:0] ir;
  logic [31:0] addr;
  logic [31:0] store_data;
  logic        load;
  logic        store;
  logic        decode_vld;
  logic        decode_rdy;
  logic        regwr_lsu;
  logic [4:0]  rd;
  logic [31:0] load_data;
  int          cycle_count = 0;

  `include "lsu_model.svh"

  lsu_top #(.MEM_WORDS(MEM_WORDS)) dut (
    .clk(clk), .rst_n(rst_n), .ir(ir), .addr(addr), .store_data(store_data),
    .load(load), .store(store), .decode_vld(decode_vld), .decode_rdy(decode_rdy),
    .regwr_lsu(regwr_lsu), .rd(rd), .load_data(load_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH time=%0t signal=%s expected=0x%08h actual=0x%08h",
               $time, name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  // Kinds 0..4 are LB LH LW LBU LHU and kinds 5..7 are SB SH SW
  function automatic logic [2:0] kind_funct3(input int kind);
    case (kind)
      0, 5:    return lsu_pkg::FUNCT3_B;
      1, 6:    return lsu_pkg::FUNCT3_H;
      3:       return lsu_pkg::FUNCT3_BU;
      4:       return lsu_pkg::FUNCT3_HU;
      default: return lsu_pkg::FUNCT3_W;
    endcase
  endfunction

  // One operation from strobe to completion
  task automatic run_op(input logic [31:0] instr, input logic [31:0] a,
                        input logic [31:0] sdata, input logic is_load,
                        input logic [31:0] exp_data);
    int lat;
    @(posedge clk);
    ir <= instr;
    addr <= a;
    store_data <= sdata;
    load <= is_load;
    store <= !is_load;
    decode_vld <= 1'b1;
    // Previous completion lasts one cycle only
    @(negedge clk);
    check_value("decode_rdy", 32'd0, 32'(decode_rdy));
    check_value("regwr_lsu", 32'd0, 32'(regwr_lsu));
    @(posedge clk);
    decode_vld <= 1'b0;
    lat = 0;
    @(negedge clk);
    while (decode_rdy !== 1'b1) begin
      check_value("regwr_lsu", 32'd0, 32'(regwr_lsu));
      lat++;
      @(negedge clk);
    end
    check_value("decode_rdy latency", 32'd2, 32'(lat));
    check_value("regwr_lsu", 32'(is_load), 32'(regwr_lsu));
    if (is_load) begin
      check_value("rd", 32'(instr[11:7]), 32'(rd));
      check_value("load_data", exp_data, load_data);
    end
  endtask

  task automatic random_op(input int kind, input int w);
    logic [2:0]  f3;
    logic [1:0]  off;
    logic [31:0] a;
    logic [31:0] sdata;
    logic [31:0] r;
    f3 = kind_funct3(kind);
    off = 2'($urandom_range(3, 0));
    if (f3[1:0] == 2'b01) off[0] = 1'b0;
    if (f3[1:0] == 2'b10) off = 2'b00;
    a = {w[29:0], off};
    r = $urandom;
    sdata = $urandom;
    // Bias toward negative bytes and halfwords
    if ($urandom_range(3, 0) != 0) sdata = sdata | 32'h0000_8080;
    if (kind < 5) begin
      run_op({r[31:15], f3, r[11:7], 7'b0000011}, a, sdata, 1'b1, expected_load(a, f3));
    end else begin
      run_op({r[31:15], f3, r[11:7], 7'b0100011}, a, sdata, 1'b0, 32'h0);
      store_bytes(a, f3, sdata);
    end
  endtask

  initial begin
    int k;
    int w;
    void'($urandom(SEED));
    rst_n = 1'b0;
    ir = 32'h0;
    addr = 32'h0;
    store_data = 32'h0;
    load = 1'b0;
    store = 1'b0;
    decode_vld = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // ==============================
    // Idle after reset
    // ==============================
    repeat (8) begin
      @(negedge clk);
      check_value("decode_rdy", 32'd0, 32'(decode_rdy));
      check_value("regwr_lsu", 32'd0, 32'(regwr_lsu));
    end

    // Fill every word, then read it all back
    for (int i = 0; i < MEM_WORDS; i++) random_op(7, i);
    for (int i = 0; i < MEM_WORDS; i++) random_op(2, i);

    // ==============================
    // Sub-word stores and loads
    // ==============================
    repeat (N_SUB_STORES) begin
      w = $urandom_range(MEM_WORDS - 1, 0);
      random_op(5 + int'($urandom_range(1, 0)), w);
      random_op(2, w);
    end
    repeat (N_SUB_LOADS) begin
      k = $urandom_range(3, 0);
      if (k >= 2) k++;
      random_op(k, $urandom_range(MEM_WORDS - 1, 0));
    end

    // Long mix of all eight operations
    repeat (N_MIX) random_op($urandom_range(7, 0), $urandom_range(MEM_WORDS - 1, 0));

    // Last completion drops after one cycle
    @(negedge clk);
    check_value("decode_rdy", 32'd0, 32'(decode_rdy));
    check_value("regwr_lsu", 32'd0, 32'(regwr_lsu));

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== design/lsu_top.sv ====
// Load/store unit top level
// Controller, store and load datapaths and the data memory on one word bus

`timescale 1ns/1ps

module lsu_top #(
  parameter int MEM_WORDS = lsu_pkg::MEM_WORDS_DEFAULT
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] ir,
  input  logic [31:0] addr,
  input  logic [31:0] store_data,
  input  logic        load,
  input  logic        store,
  input  logic        decode_vld,
  output logic        decode_rdy,
  output logic        regwr_lsu,
  output logic [4:0]  rd,
  output logic [31:0] load_data
);

  logic [2:0]  funct3;
  logic [1:0]  offset;
  logic [31:0] extracted;

  data_bus_if bus (.clk(clk));

  lsu_ctrl #(
    .MEM_WORDS (MEM_WORDS)
  ) u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .ir         (ir),
    .addr       (addr),
    .load       (load),
    .store      (store),
    .decode_vld (decode_vld),
    .bus        (bus.ctrl),
    .funct3     (funct3),
    .offset     (offset),
    .extracted  (extracted),
    .decode_rdy (decode_rdy),
    .regwr_lsu  (regwr_lsu),
    .rd         (rd),
    .load_data  (load_data)
  );

  // Store data goes straight to the lanes, so it is held until decode_rdy
  store_align u_store_align (
    .bus        (bus.align),
    .funct3     (funct3),
    .offset     (offset),
    .store_data (store_data)
  );

  load_extract u_load_extract (
    .funct3    (funct3),
    .offset    (offset),
    .rd_data   (bus.rd_data),
    .extracted (extracted)
  );

  data_sram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_sram (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus.mem)
  );

endmodule

// ==== design/data_sram.sv ====
// Data memory
// Single-port word array with byte-masked writes and a one-cycle acknowledge

`timescale 1ns/1ps

module data_sram #(
  parameter int MEM_WORDS = lsu_pkg::MEM_WORDS_DEFAULT
) (
  input logic     clk,
  input logic     rst_n,
  data_bus_if.mem bus
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [31:0]   mem [MEM_WORDS];
  logic [AW-1:0] idx;

  // Word index from the byte address
  assign idx = bus.addr[AW+1:2];

  // ==============================
  // Array access
  // ==============================
  always_ff @(posedge clk) begin
    if (bus.req) begin
      if (bus.wr_en) begin
        for (int i = 0; i < 4; i++) begin
          if (bus.mask[i]) mem[idx][8*i +: 8] <= bus.wr_data[8*i +: 8];
        end
      end else begin
        // Read word stays put until the next read
        bus.rd_data <= mem[idx];
      end
    end
  end

  // Fixed one-cycle acknowledge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= bus.req;
    end
  end

  a_req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    bus.req |=> !bus.req);

endmodule

// ==== design/load_extract.sv ====
// Load extractor
// Picks the addressed byte or halfword from the read word and extends it

`timescale 1ns/1ps

module load_extract (
  input  logic [2:0]  funct3,
  input  logic [1:0]  offset,
  input  logic [31:0] rd_data,
  output logic [31:0] extracted
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // Byte lane by offset, halfword by offset bit 1
  assign byte_sel = rd_data[{offset, 3'b000} +: 8];
  assign half_sel = offset[1] ? rd_data[31:16] : rd_data[15:0];

  always_comb begin
    case (funct3)
      lsu_pkg::FUNCT3_B: begin
        extracted = {{24{byte_sel[7]}}, byte_sel};
      end
      lsu_pkg::FUNCT3_BU: begin
        extracted = {24'b0, byte_sel};
      end
      lsu_pkg::FUNCT3_H: begin
        extracted = {{16{half_sel[15]}}, half_sel};
      end
      lsu_pkg::FUNCT3_HU: begin
        extracted = {16'b0, half_sel};
      end
      lsu_pkg::FUNCT3_W: begin
        extracted = rd_data;
      end
      default: begin
        // Reserved codes fall back to the full word
        extracted = rd_data;
      end
    endcase
  end

endmodule

// ==== design/store_align.sv ====
// Store aligner
// Moves store data into its byte lanes and builds the byte write mask

`timescale 1ns/1ps

module store_align (
  data_bus_if.align   bus,
  input  logic [2:0]  funct3,
  input  logic [1:0]  offset,
  input  logic [31:0] store_data
);

  always_comb begin
    case (funct3)
      lsu_pkg::FUNCT3_B: begin
        // Byte copied to every lane and the mask picks one
        bus.wr_data = {4{store_data[7:0]}};
        bus.mask    = 4'b0001 << offset;
      end
      lsu_pkg::FUNCT3_H: begin
        bus.wr_data = {2{store_data[15:0]}};
        bus.mask    = offset[1] ? 4'b1100 : 4'b0011;
      end
      lsu_pkg::FUNCT3_W: begin
        bus.wr_data = store_data;
        bus.mask    = 4'b1111;
      end
      default: begin
        // No store width, so no lane is written
        bus.wr_data = store_data;
        bus.mask    = 4'b0000;
      end
    endcase
  end

  // A write request always touches at least one lane
  a_mask_set: assert property (@(posedge bus.clk)
    bus.req && bus.wr_en |-> (bus.mask != 4'b0000));

endmodule

// ==== design/lsu_ctrl.sv ====
// LSU controller
// Accepts one load or store, issues the memory request and reports completion

`timescale 1ns/1ps

module lsu_ctrl #(
  parameter int MEM_WORDS = lsu_pkg::MEM_WORDS_DEFAULT
) (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::rv_instr_u ir,
  input  logic [31:0]       addr,
  input  logic              load,
  input  logic              store,
  input  logic              decode_vld,
  data_bus_if.ctrl          bus,
  output logic [2:0]        funct3,
  output logic [1:0]        offset,
  input  logic [31:0]       extracted,
  output logic              decode_rdy,
  output logic              regwr_lsu,
  output logic [4:0]        rd,
  output logic [31:0]       load_data
);

  localparam logic [1:0] S_IDLE    = 2'd0;
  localparam logic [1:0] S_ACCESS  = 2'd1;
  localparam logic [1:0] S_RESPOND = 2'd2;

  logic [1:0] state;
  logic       accept;
  logic [2:0] op_funct3;
  logic       load_q;

  assign accept = decode_vld && (state == S_IDLE);

  // Stores decode funct3 through the S-type view
  assign op_funct3 = store ? ir.stype.funct3 : ir.itype.funct3;

  // ==============================
  // FSM and request pulse
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      bus.req   <= 1'b0;
      bus.wr_en <= 1'b0;
      load_q    <= 1'b0;
    end else begin
      bus.req <= accept;
      case (state)
        S_IDLE: begin
          if (decode_vld) begin
            state     <= S_ACCESS;
            bus.wr_en <= store;
            load_q    <= load;
          end
        end
        S_ACCESS: begin
          if (bus.ack) state <= S_RESPOND;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Operation fields held for the whole access
  always_ff @(posedge clk) begin
    if (accept) begin
      funct3   <= op_funct3;
      offset   <= addr[1:0];
      rd       <= ir.itype.rd;
      bus.addr <= {addr[31:2], 2'b00};
    end
    if ((state == S_ACCESS) && bus.ack) load_data <= extracted;
  end

  assign decode_rdy = (state == S_RESPOND);
  assign regwr_lsu  = (state == S_RESPOND) && load_q;

  // ==============================
  // Checks
  // ==============================
  a_half_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    accept && (op_funct3[1:0] == 2'b01) |-> (addr[0] == 1'b0));
  a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    accept && (op_funct3[1:0] == 2'b10) |-> (addr[1:0] == 2'b00));
  a_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> (addr[31:2] < MEM_WORDS));
  // No new strobe until completion
  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    (state != S_IDLE) |-> !decode_vld);

endmodule

// ==== design/data_bus_if.sv ====
// Word-wide data bus between the LSU controller, store aligner and data memory
// Request pulse out, acknowledge pulse back one cycle later

`timescale 1ns/1ps

interface data_bus_if (
  input logic clk
);

  logic [31:0] addr;
  logic [31:0] wr_data;
  logic [3:0]  mask;
  logic        wr_en;
  logic        req;
  logic [31:0] rd_data;
  logic        ack;

  // Request side
  modport ctrl (output addr, wr_en, req, input ack);

  // Store lanes and the write request they belong to
  modport align (input clk, req, wr_en, output wr_data, mask);

  // Memory side
  modport mem (input addr, wr_data, mask, wr_en, req, output rd_data, ack);

endinterface

// ==== design/lsu_pkg.sv ====
// LSU shared definitions
// Instruction word views, load/store width codes, default memory depth

package lsu_pkg;

  // ==============================
  // Instruction word
  // ==============================

  // Loads read the I-type view, stores the S-type view
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } itype;
    struct packed {
      logic [6:0]  imm_hi;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo;
      logic [6:0]  opcode;
    } stype;
  } rv_instr_u;

  // ==============================
  // Width codes (funct3)
  // ==============================

  // Signed byte and halfword, full word
  localparam logic [2:0] FUNCT3_B  = 3'b000;
  localparam logic [2:0] FUNCT3_H  = 3'b001;
  localparam logic [2:0] FUNCT3_W  = 3'b010;

  // Zero-extended forms for loads only
  localparam logic [2:0] FUNCT3_BU = 3'b100;
  localparam logic [2:0] FUNCT3_HU = 3'b101;

  // ==============================
  // Memory
  // ==============================

  // Depth in 32-bit words
  localparam int MEM_WORDS_DEFAULT = 256;

endpackage
